//--- flist.f
+incdir+source
source/fdc_pkg.sv
source/fdc_sd_if.sv
source/host_port.sv
source/track_offset_table.sv
source/sd_fetch.sv
source/image_scanner.sv
source/fdc_controller.sv
source/fdc_top.sv
testbench/tb_disk_model.sv
testbench/tb_fdc.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -Wno-fatal -f flist.f --top-module tb_fdc -Mdir obj_dir -o tb_fdc_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_fdc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failures found" "$LOG"; then
	echo "simulation reported failures"
	exit 1
fi

exit 0

//--- testbench/tb_fdc.sv
`default_nettype none

module tb_fdc
	import fdc_pkg::*;
();

	localparam logic [31:0] DISK_BYTES = 32'h3A00;
	localparam int TRACKS      = 3;
	localparam int TRACK_UNITS = 'h13;	// 256-byte units per track
	localparam int SECTORS     = 4;
	localparam int RQM_TRIES   = 400;
	localparam int READY_TRIES = 100;
	localparam int DRAIN_TRIES = 50;

	logic        clk_sys = 1'b0;
	logic        rst;
	logic        ready;
	logic        a0;
	logic        n_rd;
	logic        n_wr;
	byte_t       din;
	byte_t       dout;
	logic        img_mounted;
	logic [31:0] img_size;
	logic [31:0] sd_lba;
	logic        sd_rd;
	logic        sd_ack;
	logic [8:0]  sd_buff_addr;
	byte_t       sd_buff_dout;
	logic        sd_buff_wr;

	// expected drive state
	byte_t mdl_cyl;
	byte_t mdl_st0;
	logic  mdl_int;
	logic  mdl_ready;
	int    mdl_sec;

	logic [15:0] lfsr;
	int byte_errs;
	int state_errs;
	int lba_errs;
	int timeout_errs;
	logic sd_rd_q;
	byte_t got_q[$];
	byte_t exp_q[$];
	string name_q[$];

	always #4 clk_sys = ~clk_sys;

	fdc_top u_fdc_top (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.ready        (ready),
		.a0           (a0),
		.n_rd         (n_rd),
		.n_wr         (n_wr),
		.din          (din),
		.dout         (dout),
		.img_mounted  (img_mounted),
		.img_size     (img_size),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_ack       (sd_ack),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr)
	);

	tb_disk_model u_disk_model (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_ack       (sd_ack),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr)
	);

	// ========================================================================
	// reference model
	// ========================================================================
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};	// x^16+x^14+x^13+x^11
	endfunction

	function automatic bit is_read_id(input byte_t op);
		return (op == 8'h0A) || (op == 8'h4A);	// mfm bit either way
	endfunction

	// 512-byte block holding the track info of a cylinder
	function automatic logic [31:0] track_block(input byte_t cyl);
		return (32'd1 + 32'(cyl) * 32'(TRACK_UNITS)) >> 1;
	endfunction

	function automatic int param_count(input byte_t op);
		if (is_read_id(op))
			return 1;
		case (op)
			8'h03, 8'h0F: return 2;
			8'h07, 8'h04: return 1;
			default:      return 0;
		endcase
	endfunction

	function automatic int result_count(input byte_t op);
		if (is_read_id(op))
			return 7;
		case (op)
			8'h03, 8'h07, 8'h0F: return 0;
			8'h08:   return mdl_int ? 2 : 1;
			default: return 1;	// drive status, invalid codes
		endcase
	endfunction

	// bit 8 set when the byte is checked
	function automatic logic [8:0] ref_reply(input byte_t op, input byte_t p1, input int idx);
		if (is_read_id(op)) begin
			if (p1[2]) begin
				// image has one side only
				case (idx)
					0:       return 9'h14C;	// abnormal, no side, head 1
					1, 2:    return 9'h100;
					default: return 9'h000;
				endcase
			end
			case (idx)
				3:       return {1'b1, mdl_cyl};
				5:       return {1'b1, 8'hC1 + 8'(mdl_sec)};
				6:       return 9'h102;
				default: return 9'h100;	// status and head
			endcase
		end
		case (op)
			8'h08:
				if (mdl_int)
					return (idx == 0) ? {1'b1, mdl_st0} : {1'b1, mdl_cyl};
			8'h04:
				if (p1[1:0] == 2'd0)
					return {1'b1, 2'b00, mdl_ready, mdl_cyl == 8'd0, 4'h0};
				else
					return 9'h101;
			default: ;
		endcase
		return 9'h180;
	endfunction

	task automatic model_update(input byte_t op, input byte_t p1, input byte_t p2);
		if (is_read_id(op)) begin
			if (!p1[2])
				mdl_sec = (mdl_sec + 1) % SECTORS;
		end else begin
			case (op)
				8'h0F: begin
					if (p2 < TRACKS) begin
						mdl_cyl = p2;
						mdl_st0 = 8'h20;
					end else begin
						mdl_st0 = 8'hE8;	// cylinder kept
					end
					mdl_int = 1'b1;
					mdl_sec = 0;
				end
				8'h07: begin
					mdl_cyl = 8'd0;
					mdl_st0 = 8'h20;
					mdl_int = 1'b1;
					mdl_sec = 0;
				end
				8'h08: mdl_int = 1'b0;
				default: ;
			endcase
		end
	endtask

	task automatic take_bits(input int n, output int val);
		int i;
		val = 0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val = (val << 1) | int'(lfsr[0]);
		end
	endtask

	// ========================================================================
	// checks and reporting
	// ========================================================================
	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			byte_errs++;
			$display("ERR t=%0t %s: got 0x%02h, expected 0x%02h", $time, name, got, exp);
		end
	endtask

	task automatic check_state(input string name, input fdc_state_t got,
		input fdc_state_t exp);
		if (got !== exp) begin
			state_errs++;
			$display("ERR t=%0t %s: got %s, expected %s", $time, name, got.name(),
				exp.name());
		end
	endtask

	task automatic check_lba(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			lba_errs++;
			$display("ERR t=%0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
		end
	endtask

	task automatic queue_check(input string name, input byte_t got, input byte_t exp);
		name_q.push_back(name);
		got_q.push_back(got);
		exp_q.push_back(exp);
	endtask

	always @(posedge clk_sys) begin
		if (got_q.size() != 0)
			check_byte(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
	end

	// header block before the image is ready, track info block after
	always @(negedge clk_sys) begin
		if (rst) begin
			sd_rd_q <= 1'b0;
		end else begin
			sd_rd_q <= sd_rd;
			if (sd_rd && !sd_rd_q)
				check_lba("sd_lba", sd_lba, mdl_ready ? track_block(mdl_cyl) : 32'd0);
		end
	end

	task automatic end_run();
		$display("errors: byte %0d, state %0d, lba %0d, timeout %0d", byte_errs,
			state_errs, lba_errs, timeout_errs);
		if (byte_errs + state_errs + lba_errs + timeout_errs == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	endtask

	// ========================================================================
	// host bus
	// ========================================================================
	task automatic bus_read(input logic sel, output byte_t val);
		a0   = sel;
		n_rd = 1'b0;
		repeat (3) @(negedge clk_sys);	// dout settles two cycles after the edge
		val  = dout;
		n_rd = 1'b1;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic bus_write(input logic sel, input byte_t val);
		a0   = sel;
		din  = val;
		n_wr = 1'b0;
		repeat (2) @(negedge clk_sys);
		n_wr = 1'b1;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic wait_rqm(input logic dio);
		byte_t msr;
		int tries;
		for (tries = 0; tries < RQM_TRIES; tries++) begin
			bus_read(1'b0, msr);
			if (msr[7] && msr[6] == dio && (msr[4] || !dio))	// results keep cb high
				return;
		end
		$display("timeout: controller never raised RQM with DIO=%0b", dio);
		timeout_errs++;
		end_run();
	endtask

	task automatic send_byte(input byte_t val);
		wait_rqm(1'b0);
		bus_write(1'b1, val);
	endtask

	task automatic recv_byte(output byte_t val);
		wait_rqm(1'b1);
		bus_read(1'b1, val);
	endtask

	task automatic run_cmd(input string name, input byte_t op, input byte_t p1,
		input byte_t p2);
		logic [8:0] exp;
		byte_t got;
		int n_par;
		int n_res;
		int i;
		n_par = param_count(op);
		n_res = result_count(op);
		send_byte(op);
		if (n_par > 0)
			send_byte(p1);
		if (n_par > 1)
			send_byte(p2);
		for (i = 0; i < n_res; i++) begin
			exp = ref_reply(op, p1, i);
			recv_byte(got);
			if (exp[8])
				queue_check($sformatf("dout %s byte %0d", name, i), got, exp[7:0]);
		end
		model_update(op, p1, p2);
		check_state({name, " end state"}, u_fdc_top.u_fdc_controller.state, ST_IDLE);
	endtask

	task automatic wait_image_ready();
		byte_t st3;
		int tries;
		for (tries = 0; tries < READY_TRIES; tries++) begin
			send_byte(8'h04);
			send_byte(8'h00);
			recv_byte(st3);
			if (st3[5])
				return;
		end
		$display("timeout: image never became ready after mount");
		timeout_errs++;
		end_run();
	endtask

	task automatic drain_checks();
		int tries;
		for (tries = 0; tries < DRAIN_TRIES; tries++) begin
			if (got_q.size() == 0)
				return;
			@(negedge clk_sys);
		end
		$display("timeout: compare queue never emptied");
		timeout_errs++;
		end_run();
	endtask

	// ========================================================================
	// test sequence
	// ========================================================================
	initial begin
		byte_t msr;
		int r;
		byte_t cyl;
		rst          = 1'b1;
		ready        = 1'b1;
		a0           = 1'b0;
		n_rd         = 1'b1;
		n_wr         = 1'b1;
		din          = 8'h00;
		img_mounted  = 1'b0;
		img_size     = 32'd0;
		lfsr         = 16'd97;
		mdl_cyl      = 8'd0;
		mdl_st0      = 8'd0;
		mdl_int      = 1'b0;
		mdl_ready    = 1'b0;
		mdl_sec      = 0;
		byte_errs    = 0;
		state_errs   = 0;
		lba_errs     = 0;
		timeout_errs = 0;
		repeat (16) @(negedge clk_sys);
		rst = 1'b0;
		repeat (2) @(negedge clk_sys);

		check_state("state after reset", u_fdc_top.u_fdc_controller.state, ST_IDLE);
		bus_read(1'b0, msr);
		queue_check("dout msr after reset", msr, 8'h80);
		run_cmd("invalid 0x1f", 8'h1F, 8'h00, 8'h00);

		// mount; the scan starts when img_mounted falls
		img_size    = DISK_BYTES;
		img_mounted = 1'b1;
		repeat (4) @(negedge clk_sys);
		img_mounted = 1'b0;
		wait_image_ready();
		mdl_ready = 1'b1;

		run_cmd("sense drive 0", 8'h04, 8'h00, 8'h00);
		run_cmd("sense drive 1", 8'h04, 8'h01, 8'h00);

		take_bits(8, r);
		cyl = byte_t'(r % TRACKS);
		run_cmd("seek", 8'h0F, 8'h00, cyl);
		run_cmd("sis after seek", 8'h08, 8'h00, 8'h00);
		run_cmd("seek to 5", 8'h0F, 8'h00, 8'd5);
		run_cmd("sis after bad seek", 8'h08, 8'h00, 8'h00);
		run_cmd("second sis", 8'h08, 8'h00, 8'h00);

		run_cmd("recalibrate", 8'h07, 8'h00, 8'h00);
		run_cmd("sis after recal", 8'h08, 8'h00, 8'h00);

		// back to the random cylinder for the id walk
		run_cmd("seek again", 8'h0F, 8'h00, cyl);
		run_cmd("sis before read id", 8'h08, 8'h00, 8'h00);
		repeat (5) run_cmd("read id", 8'h4A, 8'h00, 8'h00);
		run_cmd("read id head 1", 8'h4A, 8'h04, 8'h00);

		drain_checks();
		end_run();
	end

endmodule

`default_nettype wire

//--- testbench/tb_disk_model.sv
`default_nettype none

module tb_disk_model
	import fdc_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst,
	input  logic [31:0] sd_lba,
	input  logic        sd_rd,
	output logic        sd_ack,
	output logic [8:0]  sd_buff_addr,
	output byte_t       sd_buff_dout,
	output logic        sd_buff_wr
);

	localparam logic [2:0] PH_IDLE    = 3'd0;
	localparam logic [2:0] PH_DELAY   = 3'd1;
	localparam logic [2:0] PH_STREAM  = 3'd2;
	localparam logic [2:0] PH_END     = 3'd3;
	localparam logic [2:0] PH_RELEASE = 3'd4;

	localparam logic [31:0] TRACKS      = 32'd3;
	localparam logic [31:0] TRACK_BYTES = 32'h1300;	// 0x13 units of 256

	logic [2:0]  phase = PH_IDLE;
	logic [31:0] blk = '0;
	logic [9:0]  cnt = '0;
	logic        ack_q = 1'b0;
	logic        wr_q = 1'b0;
	logic [8:0]  addr_q = '0;
	byte_t       data_q = '0;
	string       disk_tag = "MV - CPCEMU Disk-File";
	string       track_tag = "Track-Info";

	assign sd_ack       = ack_q;
	assign sd_buff_wr   = wr_q;
	assign sd_buff_addr = addr_q;
	assign sd_buff_dout = data_q;

	// ========================================================================
	// single-sided dsk, 3 tracks, 4 sectors each
	// ========================================================================
	function automatic byte_t image_byte(input logic [31:0] a);
		logic [31:0] rel;
		logic [31:0] trk;
		logic [31:0] ofs;
		byte_t sec;
		if (a < 32'h100) begin
			if (a < 32'(disk_tag.len()))
				return disk_tag.getc(int'(a));
			case (a[7:0])
				8'h30:   return 8'd3;	// tracks
				8'h31:   return 8'd1;	// sides
				8'h33:   return 8'h13;	// track size high byte
				default: return 8'h00;
			endcase
		end
		rel = a - 32'h100;
		trk = rel / TRACK_BYTES;
		ofs = rel % TRACK_BYTES;
		if (trk < TRACKS && ofs < 32'h100) begin
			if (ofs < 32'(track_tag.len()))
				return track_tag.getc(int'(ofs));
			if (ofs == 32'h10)
				return trk[7:0];
			if (ofs == 32'h14)
				return 8'h02;	// sector size code
			if (ofs == 32'h15)
				return 8'h04;	// sector count
			if (ofs >= 32'h18 && ofs < 32'h38) begin
				sec = 8'(ofs[5:3]) - 8'd3;
				case (ofs[2:0])
					3'd0:    return trk[7:0];	// c
					3'd2:    return 8'hC1 + sec;	// r
					3'd3:    return 8'h02;	// n
					3'd7:    return 8'h02;	// 512 bytes stored
					default: return 8'h00;
				endcase
			end
			return 8'h00;
		end
		// sector data
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'hA5;
	endfunction

	// one 512-byte block per request
	always @(negedge clk_sys) begin
		if (rst) begin
			phase <= PH_IDLE;
			ack_q <= 1'b0;
			wr_q  <= 1'b0;
			cnt   <= '0;
		end else begin
			case (phase)
				PH_IDLE:
					if (sd_rd) begin
						blk   <= sd_lba;
						cnt   <= '0;
						phase <= PH_DELAY;
					end
				PH_DELAY: begin
					cnt <= cnt + 10'd1;
					if (cnt == 10'd3) begin
						ack_q <= 1'b1;
						cnt   <= '0;
						phase <= PH_STREAM;
					end
				end
				PH_STREAM: begin
					addr_q <= cnt[8:0];
					data_q <= image_byte({blk[22:0], cnt[8:0]});
					wr_q   <= 1'b1;
					cnt    <= cnt + 10'd1;
					if (cnt == 10'd511)
						phase <= PH_END;
				end
				PH_END: begin
					wr_q  <= 1'b0;
					ack_q <= 1'b0;
					phase <= PH_RELEASE;
				end
				PH_RELEASE: if (!sd_rd) phase <= PH_IDLE;
				default: phase <= PH_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/fdc_top.sv
`default_nettype none

module fdc_top
	import fdc_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst,
	input  logic        ready,
	input  logic        a0,
	input  logic        n_rd,
	input  logic        n_wr,
	input  byte_t       din,
	output byte_t       dout,
	input  logic        img_mounted,
	input  logic [31:0] img_size,
	output logic [31:0] sd_lba,
	output logic        sd_rd,
	input  logic        sd_ack,
	input  logic [8:0]  sd_buff_addr,
	input  byte_t       sd_buff_dout,
	input  logic        sd_buff_wr
);

	logic data_wr;
	logic data_rd;
	logic msr_rd;
	byte_t wr_byte;
	logic rd_load;
	byte_t rd_byte;
	logic tab_wr;
	logic [7:0] tab_wr_addr;
	track_off_t tab_wr_data;
	logic [7:0] tab_rd_addr;
	track_off_t tab_rd_data;
	logic image_ready;
	logic image_sides;
	byte_t image_tracks;
	logic disk_present;

	fdc_sd_if scan_sd ();
	fdc_sd_if ctrl_sd ();

	// a zero-size mount is an eject
	assign disk_present = image_ready && (img_size != 32'd0);

	host_port u_host_port (
		.clk_sys (clk_sys),
		.rst     (rst),
		.a0      (a0),
		.n_rd    (n_rd),
		.n_wr    (n_wr),
		.din     (din),
		.data_wr (data_wr),
		.data_rd (data_rd),
		.msr_rd  (msr_rd),
		.wr_byte (wr_byte),
		.rd_load (rd_load),
		.rd_byte (rd_byte),
		.dout    (dout)
	);

	image_scanner u_image_scanner (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.img_mounted  (img_mounted),
		.sd           (scan_sd),
		.tab_wr       (tab_wr),
		.tab_addr     (tab_wr_addr),
		.tab_data     (tab_wr_data),
		.image_ready  (image_ready),
		.image_sides  (image_sides),
		.image_tracks (image_tracks)
	);

	track_offset_table u_track_offset_table (
		.clk_sys (clk_sys),
		.wr_en   (tab_wr),
		.wr_addr (tab_wr_addr),
		.wr_data (tab_wr_data),
		.rd_addr (tab_rd_addr),
		.rd_data (tab_rd_data)
	);

	sd_fetch u_sd_fetch (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.scan         (scan_sd),
		.ctrl         (ctrl_sd),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_ack       (sd_ack),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr)
	);

	fdc_controller u_fdc_controller (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.ready        (ready),
		.data_wr      (data_wr),
		.data_rd      (data_rd),
		.msr_rd       (msr_rd),
		.wr_byte      (wr_byte),
		.rd_load      (rd_load),
		.rd_byte      (rd_byte),
		.image_ready  (disk_present),
		.image_sides  (image_sides),
		.image_tracks (image_tracks),
		.tab_addr     (tab_rd_addr),
		.tab_data     (tab_rd_data),
		.sd           (ctrl_sd)
	);

endmodule

`default_nettype wire

//--- source/fdc_controller.sv
`default_nettype none
`include "fdc_cfg.svh"

module fdc_controller
	import fdc_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst,
	input  logic       ready,
	input  logic       data_wr,
	input  logic       data_rd,
	input  logic       msr_rd,
	input  byte_t      wr_byte,
	output logic       rd_load,
	output byte_t      rd_byte,
	input  logic       image_ready,
	input  logic       image_sides,
	input  byte_t      image_tracks,
	output logic [7:0] tab_addr,
	input  track_off_t tab_data,
	fdc_sd_if.client   sd
);

	fdc_state_t state;
	fdc_cmd_t cmd;
	byte_t st0;
	byte_t st1;
	byte_t st3;
	byte_t m_status;
	byte_t pcn;		// present cylinder
	byte_t sec_idx;		// next sector in rotation
	byte_t sec_c;
	byte_t sec_h;
	byte_t sec_r;
	byte_t sec_n;
	byte_t reply;
	logic hds;
	logic ds0;
	logic int_pend;
	logic [2:0] res_idx;
	logic [2:0] walk_cnt;
	logic [8:0] sd_addr;

	function automatic fdc_cmd_t decode_cmd(input byte_t op);
		casez (op)
			8'b0000_0011: return CMD_SPECIFY;
			8'b0000_0111: return CMD_RECALIBRATE;
			8'b0000_1111: return CMD_SEEK;
			8'b0000_1000: return CMD_SENSE_INT;
			8'b0000_0100: return CMD_SENSE_DRIVE;
			8'b0?00_1010: return CMD_READ_ID;	// mfm bit ignored
			default:      return CMD_INVALID;
		endcase
	endfunction

	assign cmd = decode_cmd(wr_byte);

	// ========================================================================
	// status registers and host reply
	// ========================================================================
	assign st3 = {1'b0, ~image_ready, image_ready, (pcn == 8'd0), 4'b0000};

	always_comb begin
		m_status = 8'h00;
		m_status[7] = !(state inside {ST_RID_LOOKUP, ST_RID_FETCH, ST_RID_COUNT,
			ST_RID_WALK});		// rqm
		m_status[6] = state inside {ST_SIS_ST0, ST_SIS_PCN, ST_SDS_RESULT,
			ST_RID_RESULT, ST_INVALID};	// dio
		m_status[4] = (state != ST_IDLE);	// busy
	end

	always_comb begin
		case (state)
			ST_SIS_ST0:    reply = st0;
			ST_SIS_PCN:    reply = pcn;
			ST_SDS_RESULT: reply = ds0 ? 8'h01 : st3;	// only drive 0 exists
			ST_INVALID:    reply = `FDC_ST0_INVALID;
			ST_RID_RESULT:
				case (res_idx)
					3'd0:    reply = {st0[7:3], hds, st0[1:0]};
					3'd1:    reply = st1;
					3'd2:    reply = 8'h00;
					3'd3:    reply = sec_c;
					3'd4:    reply = sec_h;
					3'd5:    reply = sec_r;
					default: reply = sec_n;
				endcase
			default:       reply = 8'hFF;
		endcase
	end

	assign rd_load = data_rd | msr_rd;
	assign rd_byte = msr_rd ? m_status : reply;

	// track info fetch
	assign sd.req      = (state == ST_RID_FETCH) && (tab_data != '0) && !sd.busy;
	assign sd.region   = SD_TRACKINFO;
	assign sd.lba      = {17'd0, tab_data[15:1]};
	assign sd.buf_addr = sd_addr;

	// ========================================================================
	// command FSM
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state    <= ST_IDLE;
			int_pend <= 1'b0;
			pcn      <= '0;
			sec_idx  <= '0;
			st0      <= '0;
			st1      <= '0;
			hds      <= 1'b0;
			ds0      <= 1'b0;
			res_idx  <= '0;
			walk_cnt <= '0;
		end else begin
			if (!image_ready)
				sec_idx <= '0;		// new image, rotation restarts
			case (state)
				ST_IDLE:
					if (data_wr) begin
						int_pend <= 1'b0;
						case (cmd)
							CMD_SPECIFY:     state <= ST_SPECIFY1;
							CMD_RECALIBRATE: state <= ST_RECAL;
							CMD_SEEK:        state <= ST_SEEK_HEAD;
							CMD_SENSE_INT:   state <= int_pend ? ST_SIS_ST0 : ST_INVALID;
							CMD_SENSE_DRIVE: state <= ST_SDS_PARAM;
							CMD_READ_ID:     state <= ST_RID_PARAM;
							default:         state <= ST_INVALID;
						endcase
					end
				ST_SIS_ST0:  if (data_rd) state <= ST_SIS_PCN;
				ST_SIS_PCN:  if (data_rd) state <= ST_IDLE;
				ST_SDS_PARAM:
					if (data_wr) begin
						ds0   <= wr_byte[0];
						state <= ST_SDS_RESULT;
					end
				ST_SDS_RESULT: if (data_rd) state <= ST_IDLE;
				ST_SPECIFY1: if (data_wr) state <= ST_SPECIFY2;	// step rates unused
				ST_SPECIFY2: if (data_wr) state <= ST_IDLE;
				ST_RECAL:
					if (data_wr) begin
						pcn      <= '0;
						st0      <= `FDC_ST0_SEEK_OK;
						int_pend <= 1'b1;
						sec_idx  <= '0;
						state    <= ST_IDLE;
					end
				ST_SEEK_HEAD:
					if (data_wr) begin
						hds   <= wr_byte[2];
						state <= ST_SEEK_CYL;
					end
				ST_SEEK_CYL:
					if (data_wr) begin
						if ((ready && image_ready && wr_byte < image_tracks) || wr_byte == 8'd0) begin
							pcn <= wr_byte;
							st0 <= `FDC_ST0_SEEK_OK;
						end else begin
							st0 <= `FDC_ST0_SEEK_ERR;	// cylinder kept
						end
						int_pend <= 1'b1;
						sec_idx  <= '0;
						state    <= ST_IDLE;
					end
				ST_RID_PARAM:
					if (data_wr) begin
						hds     <= wr_byte[2];
						res_idx <= '0;
						if (!ready || !image_ready) begin
							st0   <= `FDC_ST0_ABNORMAL;
							st1   <= `FDC_ST1_NOT_READY;
							state <= ST_RID_RESULT;
						end else if (wr_byte[2] && !image_sides) begin
							st0   <= `FDC_ST0_NO_SIDE;
							st1   <= '0;
							state <= ST_RID_RESULT;
						end else begin
							tab_addr <= (pcn << image_sides) + {7'd0, wr_byte[2]};
							state    <= ST_RID_LOOKUP;
						end
					end
				ST_RID_LOOKUP: state <= ST_RID_FETCH;	// table read latency
				ST_RID_FETCH:
					if (tab_data == '0) begin
						st0   <= `FDC_ST0_ABNORMAL;	// track missing in image
						st1   <= `FDC_ST1_NOT_READY;
						state <= ST_RID_RESULT;
					end else if (!sd.busy) begin
						sd_addr <= {tab_data[0], `FDC_TI_SECTOR_COUNT};
						state   <= ST_RID_COUNT;
					end
				ST_RID_COUNT:
					if (!sd.busy) begin
						sd_addr[7:0] <= `FDC_TI_SECTOR_LIST + {sec_idx[4:0], 3'b000};
						sec_idx  <= (sec_idx == sd.buf_data - 8'd1) ? 8'd0 : sec_idx + 8'd1;
						walk_cnt <= '0;
						state    <= ST_RID_WALK;
					end
				ST_RID_WALK: begin
					sd_addr  <= sd_addr + 9'd1;
					walk_cnt <= walk_cnt + 3'd1;
					case (walk_cnt)	// data trails the address by one
						3'd1: sec_c <= sd.buf_data;
						3'd2: sec_h <= sd.buf_data;
						3'd3: sec_r <= sd.buf_data;
						3'd4: begin
							sec_n <= sd.buf_data;
							st0   <= '0;
							st1   <= '0;
							state <= ST_RID_RESULT;
						end
						default: ;
					endcase
				end
				ST_RID_RESULT:
					if (data_rd) begin
						res_idx <= res_idx + 3'd1;
						if (res_idx == 3'd6)
							state <= ST_IDLE;
					end
				ST_INVALID: if (data_rd) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/image_scanner.sv
`default_nettype none
`include "fdc_cfg.svh"

module image_scanner
	import fdc_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst,
	input  logic       img_mounted,
	fdc_sd_if.client   sd,
	output logic       tab_wr,
	output logic [7:0] tab_addr,
	output track_off_t tab_data,
	output logic       image_ready,
	output logic       image_sides,
	output byte_t      image_tracks
);

	scan_state_t state;
	logic mounted_q;
	logic edsk;		// 1 = extended image
	logic [8:0] pos;	// header byte on buf_data
	byte_t track_size;
	track_off_t offset;

	// header lives in block 0
	assign sd.req      = (state == SCAN_FETCH) && !sd.busy;
	assign sd.region   = SD_SECTOR;
	assign sd.lba      = '0;
	assign sd.buf_addr = pos;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state       <= SCAN_IDLE;
			mounted_q   <= 1'b0;
			image_ready <= 1'b0;
			tab_wr      <= 1'b0;
		end else begin
			mounted_q <= img_mounted;
			case (state)
				SCAN_IDLE: ;
				SCAN_FETCH:
					if (!sd.busy) begin
						pos      <= '0;
						offset   <= 16'h0001;	// first track at 0x100
						tab_addr <= '0;
						state    <= SCAN_PARSE;
					end
				SCAN_PARSE:
					if (!sd.busy) begin
						pos   <= pos + 9'd1;
						state <= SCAN_STORE;
						if (pos == 9'd0) begin
							if (sd.buf_data == "E")
								edsk <= 1'b1;
							else if (sd.buf_data == "M")
								edsk <= 1'b0;
							else
								state <= SCAN_IDLE;	// unknown format
						end else if (pos == `FDC_HDR_TRACKS) begin
							image_tracks <= sd.buf_data;
						end else if (pos == `FDC_HDR_SIDES) begin
							image_sides <= sd.buf_data[1];
						end else if (pos == `FDC_HDR_TRACK_SIZE) begin
							track_size <= sd.buf_data;
						end else if (pos >= `FDC_HDR_TABLE) begin
							if ({1'b0, tab_addr} != ({1'b0, image_tracks} << image_sides)) begin
								tab_wr <= 1'b1;
								if (edsk) begin
									// zero size marks an unformatted track
									tab_data <= (sd.buf_data != 8'd0) ? offset : '0;
									offset   <= offset + {8'd0, sd.buf_data};
								end else begin
									tab_data <= offset;
									offset   <= offset + {8'd0, track_size};
								end
							end else begin
								image_ready <= 1'b1;
								state       <= SCAN_IDLE;
							end
						end
					end
				SCAN_STORE: begin
					// also lets buf_data catch up with pos
					if (tab_wr)
						tab_addr <= tab_addr + 8'd1;
					tab_wr <= 1'b0;
					state  <= SCAN_PARSE;
				end
				default: state <= SCAN_IDLE;
			endcase
			if (mounted_q && !img_mounted) begin
				image_ready <= 1'b0;
				state       <= SCAN_FETCH;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/sd_fetch.sv
`default_nettype none
`include "fdc_cfg.svh"

module sd_fetch
	import fdc_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst,
	fdc_sd_if.fetch     scan,
	fdc_sd_if.fetch     ctrl,
	output logic [31:0] sd_lba,
	output logic        sd_rd,
	input  logic        sd_ack,
	input  logic [8:0]  sd_buff_addr,
	input  byte_t       sd_buff_dout,
	input  logic        sd_buff_wr
);

	byte_t buf_ram [0:`FDC_BUF_BYTES-1];
	logic [`FDC_ACK_SYNC_DEPTH-1:0] ack_sync;
	logic busy;
	sd_region_t cur_region;	// where the running fetch lands

	assign scan.busy = busy;
	assign ctrl.busy = busy;

	// ========================================================================
	// request handshake
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ack_sync <= '0;
			sd_rd    <= 1'b0;
			busy     <= 1'b0;
		end else begin
			ack_sync <= {ack_sync[`FDC_ACK_SYNC_DEPTH-2:0], sd_ack};
			if (ack_sync[`FDC_ACK_SYNC_DEPTH-1 -: 2] == 2'b01)
				sd_rd <= 1'b0;	// ack seen, drop the request
			if (ack_sync[`FDC_ACK_SYNC_DEPTH-1 -: 2] == 2'b10)
				busy <= 1'b0;
			if (!busy && (scan.req || ctrl.req)) begin
				sd_rd <= 1'b1;
				busy  <= 1'b1;
			end
		end
	end

	// scanner has priority
	always_ff @(posedge clk_sys) begin
		if (!busy) begin
			if (scan.req) begin
				sd_lba     <= scan.lba;
				cur_region <= scan.region;
			end else if (ctrl.req) begin
				sd_lba     <= ctrl.lba;
				cur_region <= ctrl.region;
			end
		end
	end

	// sector buffer, one read port per client
	always_ff @(posedge clk_sys) begin
		if (sd_buff_wr && sd_ack)
			buf_ram[{cur_region, sd_buff_addr}] <= sd_buff_dout;
		scan.buf_data <= buf_ram[{scan.region, scan.buf_addr}];
		ctrl.buf_data <= buf_ram[{ctrl.region, ctrl.buf_addr}];
	end

endmodule

`default_nettype wire

//--- source/track_offset_table.sv
`default_nettype none
`include "fdc_cfg.svh"

module track_offset_table
	import fdc_pkg::*;
(
	input  logic       clk_sys,
	input  logic       wr_en,
	input  logic [7:0] wr_addr,
	input  track_off_t wr_data,
	input  logic [7:0] rd_addr,
	output track_off_t rd_data
);

	// one slot per track and side
	track_off_t slots [0:`FDC_TRACK_SLOTS-1];

	always_ff @(posedge clk_sys) begin
		if (wr_en)
			slots[wr_addr] <= wr_data;
		rd_data <= slots[rd_addr];
	end

endmodule

`default_nettype wire

//--- source/host_port.sv
`default_nettype none

module host_port
	import fdc_pkg::*;
(
	input  logic  clk_sys,
	input  logic  rst,
	input  logic  a0,
	input  logic  n_rd,
	input  logic  n_wr,
	input  byte_t din,
	output logic  data_wr,
	output logic  data_rd,
	output logic  msr_rd,
	output byte_t wr_byte,
	input  logic  rd_load,
	input  byte_t rd_byte,
	output byte_t dout
);

	logic rd_lvl;
	logic wr_lvl;
	logic rd_prev;
	logic wr_prev;

	assign rd_lvl = n_wr & ~n_rd;
	assign wr_lvl = ~n_wr & n_rd;

	// strobes land one cycle after the edge is seen
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			rd_prev <= 1'b0;
			wr_prev <= 1'b0;
			data_wr <= 1'b0;
			data_rd <= 1'b0;
			msr_rd  <= 1'b0;
		end else begin
			rd_prev <= rd_lvl;
			wr_prev <= wr_lvl;
			data_wr <= wr_lvl & ~wr_prev & a0;
			data_rd <= rd_lvl & ~rd_prev & a0;
			msr_rd  <= rd_lvl & ~rd_prev & ~a0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_lvl && !wr_prev)
			wr_byte <= din;
		if (rd_load)
			dout <= rd_byte;	// held until the next read
	end

endmodule

`default_nettype wire

//--- source/fdc_sd_if.sv
`default_nettype none

// block fetch request plus buffer read-back
interface fdc_sd_if
	import fdc_pkg::*;
();

	logic       req;		// one-cycle pulse, only while busy is low
	sd_region_t region;
	logic [31:0] lba;
	logic [8:0] buf_addr;
	byte_t      buf_data;	// one cycle behind buf_addr
	logic       busy;

	modport client (
		output req, region, lba, buf_addr,
		input  buf_data, busy
	);

	modport fetch (
		input  req, region, lba, buf_addr,
		output buf_data, busy
	);

endinterface

`default_nettype wire

//--- source/fdc_pkg.sv
`default_nettype none

package fdc_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] track_off_t;	// 256-byte units, zero = no track

	// ========================================================================
	// command engine
	// ========================================================================
	typedef enum logic [4:0] {
		ST_IDLE,
		ST_SIS_ST0,		// sense interrupt status results
		ST_SIS_PCN,
		ST_SDS_PARAM,		// sense drive status
		ST_SDS_RESULT,
		ST_SPECIFY1,
		ST_SPECIFY2,
		ST_RECAL,
		ST_SEEK_HEAD,
		ST_SEEK_CYL,
		ST_RID_PARAM,		// read id
		ST_RID_LOOKUP,
		ST_RID_FETCH,
		ST_RID_COUNT,
		ST_RID_WALK,
		ST_RID_RESULT,
		ST_INVALID
	} fdc_state_t;

	typedef enum logic [2:0] {
		CMD_SPECIFY,
		CMD_RECALIBRATE,
		CMD_SEEK,
		CMD_SENSE_INT,
		CMD_SENSE_DRIVE,
		CMD_READ_ID,
		CMD_INVALID
	} fdc_cmd_t;

	// image header walk
	typedef enum logic [1:0] {
		SCAN_IDLE,
		SCAN_FETCH,
		SCAN_PARSE,
		SCAN_STORE
	} scan_state_t;

	// top address bit of the sector buffer
	typedef enum logic {
		SD_TRACKINFO = 1'b0,
		SD_SECTOR    = 1'b1
	} sd_region_t;

endpackage

`default_nettype wire

//--- source/fdc_cfg.svh
`ifndef FDC_CFG_SVH
`define FDC_CFG_SVH

// disk information block offsets
`define FDC_HDR_TRACKS       8'h30
`define FDC_HDR_SIDES        8'h31
`define FDC_HDR_TRACK_SIZE   8'h33	// high byte of track size
`define FDC_HDR_TABLE        8'h34	// edsk track size table

// track information block offsets
`define FDC_TI_SECTOR_COUNT  8'h15
`define FDC_TI_SECTOR_LIST   8'h18	// 8 bytes per entry

// result status codes
`define FDC_ST0_SEEK_OK      8'h20
`define FDC_ST0_SEEK_ERR     8'hE8
`define FDC_ST0_ABNORMAL     8'h40
`define FDC_ST0_NO_SIDE      8'h48
`define FDC_ST0_INVALID      8'h80
`define FDC_ST1_NOT_READY    8'h05

// sizes
`define FDC_TRACK_SLOTS      256
`define FDC_ACK_SYNC_DEPTH   6
`define FDC_BUF_BYTES        1024

`endif
